// ==== sim/conv_testdata.txt ====
// Per test: 36 weights (out ch, in ch, kernel row, kernel col), 32 pixels (in ch, row, col),
// then 32 expected outputs (out ch, row, col), all 16-bit hex
// Test 1: identity kernels
0000 0000 0000 0000 0001 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0001 0000 0000 0000 0000
0011 0022 0033 0044 0055 0066 0077 0088
0099 00AA 00BB 00CC 00DD 00EE 00FF 0100
7FFF 8000 FFFF 0001 1234 EDCC 0BAD F00D
0101 FEFE 2468 DB98 4000 C000 0007 FFF9
0011 0022 0033 0044 0055 0066 0077 0088
0099 00AA 00BB 00CC 00DD 00EE 00FF 0100
7FFF 8000 FFFF 0001 1234 EDCC 0BAD F00D
0101 FEFE 2468 DB98 4000 C000 0007 FFF9
// Test 2: all-ones kernels, plane 0 counts up, plane 1 all ones
0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0002 0003 0004 0005 0006 0007 0008
0009 000A 000B 000C 000D 000E 000F 0010
0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001
0012 001E 0024 001A 0027 003F 0048 0033
003F 0063 006C 004B 0032 004E 0054 003A
0012 001E 0024 001A 0027 003F 0048 0033
003F 0063 006C 004B 0032 004E 0054 003A
// Test 3: random kernels on out ch 0, saturating centre taps on out ch 1
0001 FFFE 0000 0003 0001 FFFF 0000 0002 FFFF
FFFF 0000 0002 0001 FFFD 0000 0002 0001 FFFE
0000 0000 0000 0000 7FFF 0000 0000 0000 0000
0000 0000 0000 0000 8000 0000 0000 0000 0000
0002 FFFF 0000 0003 FFFE 0001 0003 FFFF
0000 0002 FFFD 0001 0001 FFFF 0002 FFFE
0001 0000 FFFE 0001 0003 FFFF 0001 0000
FFFF 0002 0000 FFFD 0002 0001 FFFF 0001
0000 0008 0006 FFFE FFE9 0004 0007 0004
0006 FFFC 0005 0000 0000 FFFC 0005 FFFB
7FFE 8001 7FFF 7FFF 8000 7FFF 7FFF 8001
7FFF FFFE 8000 7FFF 8000 8000 7FFF 8000

// ==== filelist.f ====
+incdir+hw
hw/cnn_pkg.sv
hw/conv_input_replay.sv
hw/conv_3x3_engine.sv
hw/conv_channel_adder.sv
hw/conv_output_align.sv
hw/cnn_conv_3x3_layer.sv
sim/conv_checker.sv
sim/tb_cnn_conv_3x3.sv

// ==== Bender.yml ====
package:
  name: cnn_conv_3x3

sources:
  - include_dirs:
      - hw
    files:
      - hw/cnn_pkg.sv
      - hw/conv_input_replay.sv
      - hw/conv_3x3_engine.sv
      - hw/conv_channel_adder.sv
      - hw/conv_output_align.sv
      - hw/cnn_conv_3x3_layer.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/conv_checker.sv
      - sim/tb_cnn_conv_3x3.sv

// ==== sim/tb_cnn_conv_3x3.sv ====
`include "cnn_cfg.svh"

module tb_cnn_conv_3x3;
	timeunit 1ns;
	timeprecision 1ps;
	import cnn_pkg::*;

	localparam int DW         = `CNN_DATA_WIDTH;
	localparam int PLANE      = `CNN_IMAGE_WIDTH * `CNN_IMAGE_HEIGHT;
	localparam int NUM_WGT    = `CNN_CH_IN * `CNN_CH_OUT * `CNN_KERNEL * `CNN_KERNEL;
	localparam int NUM_PIX    = `CNN_CH_IN * PLANE;
	localparam int OUT_WORDS  = `CNN_CH_OUT * PLANE;
	localparam int TEST_WORDS = NUM_WGT + NUM_PIX + OUT_WORDS;
	localparam int NUM_TESTS  = 3;
	localparam int TIMEOUT    = 2000;
	localparam logic [31:0] SEED = 32'haa2d_ca97;

	logic          clk = 1'b0;
	logic          reset;
	pxl_stream_t   pxl_in;
	pxl_stream_t   weight_in;
	pxl_stream_t   pxl_out;
	int            word_cnt;
	int            pass_cnt;
	int            fail_cnt;
	logic [DW-1:0] test_mem [NUM_TESTS * TEST_WORDS];
	bit            timed_out = 1'b0;

	always #20 clk = ~clk;

	cnn_conv_3x3_layer i_dut (
		.clk      (clk),
		.reset    (reset),
		.pxl_in   (pxl_in),
		.weight_in(weight_in),
		.pxl_out  (pxl_out)
	);

	conv_checker i_checker (
		.clk     (clk),
		.reset   (reset),
		.pxl_out (pxl_out),
		.word_cnt(word_cnt),
		.pass_cnt(pass_cnt),
		.fail_cnt(fail_cnt)
	);

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk);
		reset     <= 1'b1;
		pxl_in    <= '0;
		weight_in <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	endtask

	// One strobe followed by a random number of idle cycles
	task automatic send_word(input bit to_weights, input logic [DW-1:0] word);
		int gap;
		gap = $urandom % 4;
		@(posedge clk);
		weight_in <= '{valid: to_weights, data: word};
		pxl_in    <= '{valid: !to_weights, data: word};
		if (gap > 0) begin
			@(posedge clk);
			weight_in.valid <= 1'b0;
			pxl_in.valid    <= 1'b0;
			repeat (gap - 1) @(posedge clk);
		end
	endtask

	task automatic end_stimulus();
		@(posedge clk);
		weight_in.valid <= 1'b0;
		pxl_in.valid    <= 1'b0;
	endtask

	task automatic wait_outputs(input int test_no);
		int cycles;
		cycles = 0;
		while (word_cnt < OUT_WORDS && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (word_cnt < OUT_WORDS) begin
			$display("test %0d: outputs stopped after %0d of %0d words",
				test_no, word_cnt, OUT_WORDS);
			timed_out = 1'b1;
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int base;
		reset     = 1'b1;
		pxl_in    = '0;
		weight_in = '0;
		void'($urandom(SEED));
		$readmemh("sim/conv_testdata.txt", test_mem);
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			base = t * TEST_WORDS;
			i_checker.start_test(t + 1);
			for (int i = 0; i < OUT_WORDS; i++) begin
				i_checker.expect_word(test_mem[base + NUM_WGT + NUM_PIX + i]);
			end
			apply_reset();
			// Weights always ahead of the image
			for (int i = 0; i < NUM_WGT; i++) begin
				send_word(1'b1, test_mem[base + i]);
			end
			for (int i = 0; i < NUM_PIX; i++) begin
				send_word(1'b0, test_mem[base + NUM_WGT + i]);
			end
			end_stimulus();
			wait_outputs(t + 1);
			// Quiet window where any stray word shows up in the checker
			for (int i = 0; i < PLANE && !timed_out; i++) begin
				@(posedge clk);
			end
		end
		$display("passed tests: %0d, failures: %0d", pass_cnt, fail_cnt);
		if (!timed_out && fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== sim/conv_checker.sv ====
`include "cnn_cfg.svh"

module conv_checker (
	input  logic                 clk,
	input  logic                 reset,
	input  cnn_pkg::pxl_stream_t pxl_out,
	output int                   word_cnt,
	output int                   pass_cnt,
	output int                   fail_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DW        = `CNN_DATA_WIDTH;
	localparam int PLANE     = `CNN_IMAGE_WIDTH * `CNN_IMAGE_HEIGHT;
	localparam int OUT_WORDS = `CNN_CH_OUT * PLANE;

	logic [DW-1:0] exp_q [$];
	logic [DW-1:0] exp_word;
	int            test_id    = 0;
	int            err_cnt    = 0;
	bit            armed      = 1'b0;
	logic          reset_q    = 1'b0;
	longint        cycle      = 0;
	longint        last_cycle = 0;

	initial begin
		word_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
	end

	task automatic start_test(input int id);
		test_id  = id;
		err_cnt  = 0;
		word_cnt = 0;
		armed    = 1'b1;
		exp_q.delete();
	endtask

	task automatic expect_word(input logic [DW-1:0] word);
		exp_q.push_back(word);
	endtask

	task automatic report_test();
		if (err_cnt == 0) begin
			pass_cnt++;
			$display("test %0d: %0d words, no errors, PASS", test_id, word_cnt);
		end else begin
			fail_cnt++;
			$display("test %0d: %0d words, %0d errors, FAIL", test_id, word_cnt, err_cnt);
		end
		armed = 1'b0;
	endtask

	task automatic check_word();
		exp_word = exp_q.pop_front();
		if (pxl_out.data !== exp_word) begin
			$display("ERR pxl_out[%0d]: got %h, expected %h", word_cnt, pxl_out.data, exp_word);
			err_cnt++;
		end
		// First plane leaves a full FIFO, so one word per cycle
		if (word_cnt > 0 && word_cnt < PLANE && cycle != last_cycle + 1) begin
			$display("test %0d: gap in the first output plane before word %0d",
				test_id, word_cnt);
			err_cnt++;
		end
		last_cycle = cycle;
		word_cnt++;
		if (word_cnt == OUT_WORDS)
			report_test();
	endtask

	always @(posedge clk) begin
		reset_q <= reset;
	end

	// Sampled mid-cycle where the outputs are settled
	always @(negedge clk) begin
		cycle++;
		if (reset_q) begin
			if (pxl_out.valid !== 1'b0) begin
				$display("test %0d: pxl_out valid is not low during reset", test_id);
				fail_cnt++;
			end
		end else if (pxl_out.valid) begin
			if (!armed) begin
				$display("test %0d: extra output word %h after %0d words",
					test_id, pxl_out.data, word_cnt);
				fail_cnt++;
			end else begin
				check_word();
			end
		end
	end

endmodule

// ==== hw/cnn_conv_3x3_layer.sv ====
module cnn_conv_3x3_layer (
	input  logic                 clk,
	input  logic                 reset,
	input  cnn_pkg::pxl_stream_t pxl_in,
	input  cnn_pkg::pxl_stream_t weight_in,
	output cnn_pkg::pxl_stream_t pxl_out
);
	import cnn_pkg::*;

	pxl_stream_t  replay_pxl;
	psum_stream_t engine_psum;
	pxl_stream_t  adder_pxl;

	// Image store, replayed once per output channel
	conv_input_replay i_replay (
		.clk    (clk),
		.reset  (reset),
		.pxl_in (pxl_in),
		.pxl_out(replay_pxl)
	);

	conv_3x3_engine i_engine (
		.clk      (clk),
		.reset    (reset),
		.weight_in(weight_in),
		.pxl_in   (replay_pxl),
		.psum_out (engine_psum)
	);

	// Sum over input channels
	conv_channel_adder i_adder (
		.clk    (clk),
		.reset  (reset),
		.psum_in(engine_psum),
		.pxl_out(adder_pxl)
	);

	conv_output_align i_align (
		.clk    (clk),
		.reset  (reset),
		.pxl_in (adder_pxl),
		.pxl_out(pxl_out)
	);

endmodule

// ==== hw/conv_output_align.sv ====
`include "cnn_cfg.svh"

module conv_output_align (
	input  logic                 clk,
	input  logic                 reset,
	input  cnn_pkg::pxl_stream_t pxl_in,
	output cnn_pkg::pxl_stream_t pxl_out
);

	localparam int DW    = `CNN_DATA_WIDTH;
	localparam int DEPTH = `CNN_IMAGE_WIDTH * `CNN_IMAGE_HEIGHT;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic signed [DW-1:0] fifo_mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 full;
	logic                 empty;
	logic                 read_en;
	logic                 rd;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign rd    = read_en && !empty;

	assign pxl_out = '{valid: rd, data: fifo_mem[rd_ptr]};

	always_ff @(posedge clk) begin
		if (pxl_in.valid) begin
			fifo_mem[wr_ptr] <= pxl_in.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			read_en <= 1'b0;
		end else begin
			// Stays on once the first plane is buffered
			if (full)
				read_en <= 1'b1;
			if (pxl_in.valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(pxl_in.valid) - CNT_W'(rd);
		end
	end

	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset) pxl_in.valid |-> !(full && !rd)
	);

endmodule

// ==== hw/conv_channel_adder.sv ====
`include "cnn_cfg.svh"

module conv_channel_adder (
	input  logic                  clk,
	input  logic                  reset,
	input  cnn_pkg::psum_stream_t psum_in,
	output cnn_pkg::pxl_stream_t  pxl_out
);

	localparam int DW    = `CNN_DATA_WIDTH;
	localparam int AW    = `CNN_ACC_WIDTH;
	localparam int PLANE = `CNN_IMAGE_WIDTH * `CNN_IMAGE_HEIGHT;
	localparam int CH_IN = `CNN_CH_IN;
	localparam int PIX_W = $clog2(PLANE);
	localparam int CI_W  = (CH_IN > 1) ? $clog2(CH_IN) : 1;

	localparam logic signed [AW-1:0] SAT_MAX = AW'((1 <<< (DW - 1)) - 1);
	localparam logic signed [AW-1:0] SAT_MIN = -SAT_MAX - 1;

	logic signed [AW-1:0] psum_mem [PLANE];
	logic signed [AW-1:0] sum;
	logic [PIX_W-1:0]     pix_cnt;
	logic [CI_W-1:0]      ch_cnt;

	// First channel starts a fresh sum
	assign sum = (ch_cnt == '0) ? psum_in.data : psum_mem[pix_cnt] + psum_in.data;

	always_ff @(posedge clk) begin
		if (psum_in.valid) begin
			psum_mem[pix_cnt] <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt       <= '0;
			ch_cnt        <= '0;
			pxl_out.valid <= 1'b0;
		end else begin
			pxl_out.valid <= psum_in.valid && (ch_cnt == CI_W'(CH_IN - 1));
			if (psum_in.valid) begin
				if (pix_cnt == PIX_W'(PLANE - 1)) begin
					pix_cnt <= '0;
					ch_cnt  <= (ch_cnt == CI_W'(CH_IN - 1)) ? '0 : ch_cnt + 1'b1;
				end else begin
					pix_cnt <= pix_cnt + 1'b1;
				end
			end
		end
		// Clip to the signed 16-bit range
		if (sum > SAT_MAX)
			pxl_out.data <= SAT_MAX[DW-1:0];
		else if (sum < SAT_MIN)
			pxl_out.data <= SAT_MIN[DW-1:0];
		else
			pxl_out.data <= sum[DW-1:0];
	end

endmodule

// ==== hw/conv_3x3_engine.sv ====
`include "cnn_cfg.svh"

module conv_3x3_engine (
	input  logic                  clk,
	input  logic                  reset,
	input  cnn_pkg::pxl_stream_t  weight_in,
	input  cnn_pkg::pxl_stream_t  pxl_in,
	output cnn_pkg::psum_stream_t psum_out
);
	import cnn_pkg::*;

	localparam int DW      = `CNN_DATA_WIDTH;
	localparam int AW      = `CNN_ACC_WIDTH;
	localparam int W       = `CNN_IMAGE_WIDTH;
	localparam int H       = `CNN_IMAGE_HEIGHT;
	localparam int K       = `CNN_KERNEL;
	localparam int KK      = K * K;
	localparam int PLANE   = W * H;
	localparam int PAIRS   = `CNN_CH_IN * `CNN_CH_OUT;
	localparam int NUM_WGT = PAIRS * KK;
	localparam int WI_W    = $clog2(NUM_WGT);
	localparam int SC_W    = $clog2(PLANE + W + 1);
	localparam int PL_W    = (PAIRS > 1) ? $clog2(PAIRS) : 1;
	localparam int ROW_W   = $clog2(H);
	localparam int COL_W   = $clog2(W);

	engine_state_e        state;
	logic signed [DW-1:0] wgt_mem [NUM_WGT];
	logic [WI_W-1:0]      wgt_idx;
	logic signed [DW-1:0] lb0 [W];
	logic signed [DW-1:0] lb1 [W];
	logic signed [DW-1:0] win [K][K];
	logic signed [DW-1:0] shift_px;
	logic                 shift_en;
	logic [SC_W-1:0]      shift_cnt;
	logic [PL_W-1:0]      plane_cnt;
	logic                 win_valid;
	logic [ROW_W-1:0]     ctr_row;
	logic [COL_W-1:0]     ctr_col;
	logic [PL_W-1:0]      ctr_plane;
	logic signed [AW-1:0] mac_sum;

	////////////////////////////////////////
	// Weight memory
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (weight_in.valid) begin
			wgt_mem[wgt_idx] <= weight_in.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wgt_idx <= '0;
		end else if (weight_in.valid) begin
			wgt_idx <= (wgt_idx == WI_W'(NUM_WGT - 1)) ? '0 : wgt_idx + 1'b1;
		end
	end

	////////////////////////////////////////
	// Line buffers and window
	////////////////////////////////////////

	// Zeros pushed in while flushing the last rows
	assign shift_en = pxl_in.valid || (state == FLUSH);
	assign shift_px = (state == FLUSH) ? '0 : pxl_in.data;

	always_ff @(posedge clk) begin
		if (shift_en) begin
			lb0[0] <= shift_px;
			lb1[0] <= lb0[W-1];
			for (int i = 1; i < W; i++) begin
				lb0[i] <= lb0[i-1];
				lb1[i] <= lb1[i-1];
			end
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K - 1; c++) begin
					win[r][c] <= win[r][c+1];
				end
			end
			win[0][K-1] <= lb1[W-1];
			win[1][K-1] <= lb0[W-1];
			win[2][K-1] <= shift_px;
		end
	end

	// Shift counter per plane with W+1 flush shifts after the last pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			shift_cnt <= '0;
			plane_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (pxl_in.valid) begin
						state     <= RUN;
						shift_cnt <= SC_W'(1);
					end
				end
				RUN: begin
					if (pxl_in.valid) begin
						shift_cnt <= shift_cnt + 1'b1;
						if (shift_cnt == SC_W'(PLANE - 1)) begin
							state <= FLUSH;
						end
					end
				end
				FLUSH: begin
					if (shift_cnt == SC_W'(PLANE + W)) begin
						state     <= IDLE;
						shift_cnt <= '0;
						plane_cnt <= (plane_cnt == PL_W'(PAIRS - 1)) ? '0 : plane_cnt + 1'b1;
					end else begin
						shift_cnt <= shift_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Window centre becomes valid once W+1 pixels are behind it
	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
			ctr_row   <= '0;
			ctr_col   <= '0;
			ctr_plane <= '0;
		end else begin
			win_valid <= shift_en && (shift_cnt >= SC_W'(W + 1));
			if (shift_en && shift_cnt == SC_W'(W + 1)) begin
				ctr_row   <= '0;
				ctr_col   <= '0;
				ctr_plane <= plane_cnt;
			end else if (shift_en && shift_cnt > SC_W'(W + 1)) begin
				if (ctr_col == COL_W'(W - 1)) begin
					ctr_col <= '0;
					ctr_row <= ctr_row + 1'b1;
				end else begin
					ctr_col <= ctr_col + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Multiply-accumulate
	////////////////////////////////////////

	always_comb begin
		logic signed [DW-1:0] px;
		logic signed [AW-1:0] acc;
		acc = '0;
		for (int kr = 0; kr < K; kr++) begin
			for (int kc = 0; kc < K; kc++) begin
				px = win[kr][kc];
				// Same padding
				if ((kr == 0 && ctr_row == '0) || (kr == K - 1 && ctr_row == ROW_W'(H - 1)))
					px = '0;
				if ((kc == 0 && ctr_col == '0) || (kc == K - 1 && ctr_col == COL_W'(W - 1)))
					px = '0;
				acc = acc + px * wgt_mem[ctr_plane * KK + kr * K + kc];
			end
		end
		mac_sum = acc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			psum_out.valid <= 1'b0;
		end else begin
			psum_out.valid <= win_valid;
		end
		psum_out.data <= mac_sum;
	end

	// Weights belong before the image
	a_no_weight_in_run: assert property (
		@(posedge clk) disable iff (reset) weight_in.valid |-> state != RUN
	);

endmodule

// ==== hw/conv_input_replay.sv ====
`include "cnn_cfg.svh"

module conv_input_replay (
	input  logic                 clk,
	input  logic                 reset,
	input  cnn_pkg::pxl_stream_t pxl_in,
	output cnn_pkg::pxl_stream_t pxl_out
);
	import cnn_pkg::*;

	localparam int DW      = `CNN_DATA_WIDTH;
	localparam int PLANE   = `CNN_IMAGE_WIDTH * `CNN_IMAGE_HEIGHT;
	localparam int CH_IN   = `CNN_CH_IN;
	localparam int CH_OUT  = `CNN_CH_OUT;
	localparam int GAP_LEN = `CNN_FLUSH_GAP;
	localparam int DEPTH   = CH_IN * PLANE;
	localparam int ADDR_W  = $clog2(DEPTH);
	localparam int PIX_W   = $clog2(PLANE);
	localparam int CI_W    = (CH_IN > 1) ? $clog2(CH_IN) : 1;
	localparam int CO_W    = (CH_OUT > 1) ? $clog2(CH_OUT) : 1;
	localparam int GAP_W   = $clog2(GAP_LEN);

	replay_state_e        state;
	logic signed [DW-1:0] img_mem [DEPTH];
	logic [ADDR_W-1:0]    wr_addr;
	logic [ADDR_W-1:0]    rd_addr;
	logic [PIX_W-1:0]     pix_cnt;
	logic [GAP_W-1:0]     gap_cnt;
	logic [CI_W-1:0]      ch_in_cnt;
	logic [CO_W-1:0]      ch_out_cnt;

	// Whole image kept in channel-major order
	always_ff @(posedge clk) begin
		if (state == LOAD && pxl_in.valid) begin
			img_mem[wr_addr] <= pxl_in.data;
		end
	end

	assign rd_addr = ADDR_W'(ch_in_cnt * PLANE + pix_cnt);
	assign pxl_out = '{valid: (state == PLAY), data: img_mem[rd_addr]};

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= LOAD;
			wr_addr    <= '0;
			pix_cnt    <= '0;
			gap_cnt    <= '0;
			ch_in_cnt  <= '0;
			ch_out_cnt <= '0;
		end else begin
			case (state)
				LOAD: begin
					if (pxl_in.valid) begin
						if (wr_addr == ADDR_W'(DEPTH - 1)) begin
							wr_addr <= '0;
							state   <= PLAY;
						end else begin
							wr_addr <= wr_addr + 1'b1;
						end
					end
				end
				PLAY: begin
					if (pix_cnt == PIX_W'(PLANE - 1)) begin
						pix_cnt <= '0;
						gap_cnt <= '0;
						state   <= GAP;
					end else begin
						pix_cnt <= pix_cnt + 1'b1;
					end
				end
				GAP: begin
					if (gap_cnt == GAP_W'(GAP_LEN - 1)) begin
						state <= PLAY;
						// Next input plane or next output channel
						if (ch_in_cnt == CI_W'(CH_IN - 1)) begin
							ch_in_cnt <= '0;
							if (ch_out_cnt == CO_W'(CH_OUT - 1)) begin
								ch_out_cnt <= '0;
								state      <= LOAD;
							end else begin
								ch_out_cnt <= ch_out_cnt + 1'b1;
							end
						end else begin
							ch_in_cnt <= ch_in_cnt + 1'b1;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= LOAD;
			endcase
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// New image only once the replay of the last one is over
	a_no_input_during_replay: assert property (
		@(posedge clk) disable iff (reset) pxl_in.valid |-> state == LOAD
	);

endmodule

// ==== hw/cnn_pkg.sv ====
`include "cnn_cfg.svh"

package cnn_pkg;

	////////////////////////////////////////
	// Streams between the blocks
	////////////////////////////////////////

	typedef struct packed {
		logic                              valid;
		logic signed [`CNN_DATA_WIDTH-1:0] data;
	} pxl_stream_t;

	// Engine output per channel pair
	typedef struct packed {
		logic                             valid;
		logic signed [`CNN_ACC_WIDTH-1:0] data;
	} psum_stream_t;

	////////////////////////////////////////
	// FSM states
	////////////////////////////////////////

	typedef enum logic [1:0] {LOAD, PLAY, GAP} replay_state_e;

	typedef enum logic [1:0] {IDLE, RUN, FLUSH} engine_state_e;

endpackage

// ==== hw/cnn_cfg.svh ====
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// Pixel, weight and result width
`define CNN_DATA_WIDTH 16
`define CNN_ACC_WIDTH 40

// Plane geometry
`define CNN_IMAGE_WIDTH 4
`define CNN_IMAGE_HEIGHT 4

`define CNN_CH_IN 2
`define CNN_CH_OUT 2
`define CNN_KERNEL 3

// Idle cycles after each replayed plane, enough to flush the window
`define CNN_FLUSH_GAP (`CNN_IMAGE_WIDTH + 2)

`endif
